//--- hw/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// --------------------------------------------------
// cache geometry
// --------------------------------------------------

`define ICACHE_INDEX_BITS   4   // 16 lines
`define ICACHE_OFFSET_BITS  4   // 16 byte lines
`define ICACHE_LINE_WORDS   4   // words per line

// derived sizes
`define ICACHE_LINES        (1 << `ICACHE_INDEX_BITS)
`define ICACHE_TAG_BITS     (32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_WORD_BITS    (`ICACHE_OFFSET_BITS - 2)  // word select inside a line
`define ICACHE_LINE_BITS    (`ICACHE_LINE_WORDS * 32)

// --------------------------------------------------
// address map
// --------------------------------------------------

// first fetch after reset
`define IFETCH_RESET_PC     32'ha000_0000

// top nibble of the region that takes multi-beat requests
`define IFETCH_BURST_REGION 4'ha

`endif

//--- hw/ifetch_pkg.sv
package ifetch_pkg;

    // --------------------------------------------------
    // basic types
    // --------------------------------------------------

    typedef logic [31:0] word_t;  // instruction / data word
    typedef logic [31:0] addr_t;  // byte address

    // --------------------------------------------------
    // sequencer states
    // --------------------------------------------------

    // cache line sequencer
    typedef enum logic [1:0] {
        IC_IDLE,     // lookup, hits answered from here
        IC_REFILL,   // line requested, beats shifting in
        IC_RESPOND   // line complete, tag written
    } icache_state_e;

    // memory side of a refill
    typedef enum logic [1:0] {
        RM_IDLE,
        RM_REQUEST,  // mem_req up, waiting for gnt
        RM_RECEIVE   // waiting for rvalid beats
    } refill_state_e;

    // program counter machine
    typedef enum logic [1:0] {
        FE_RUN,   // nothing outstanding
        FE_WAIT,  // fetch outstanding
        FE_DROP   // fetch outstanding, redirect pending
    } fetch_state_e;

endpackage

//--- hw/icache.sv
`timescale 1ns/10ps
`include "ifetch_defines.svh"

module icache (
    input  logic               clock,
    input  logic               reset,
    // fetch side
    input  logic               fetch_valid,
    input  ifetch_pkg::addr_t  fetch_addr,
    output logic               fetch_ready,
    output ifetch_pkg::word_t  fetch_data,
    // refill side
    output logic               refill_valid,
    output ifetch_pkg::addr_t  refill_addr,
    output logic [7:0]         refill_len,
    output logic               refill_burst,
    input  logic               refill_beat,
    input  ifetch_pkg::word_t  refill_data
);
    import ifetch_pkg::*;

    // --------------------------------------------------
    // address split
    // --------------------------------------------------

    logic [`ICACHE_TAG_BITS-1:0]   addr_tag;
    logic [`ICACHE_INDEX_BITS-1:0] line_idx;
    logic [`ICACHE_WORD_BITS-1:0]  word_sel;

    assign addr_tag = fetch_addr[31 -: `ICACHE_TAG_BITS];
    assign line_idx = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign word_sel = fetch_addr[2 +: `ICACHE_WORD_BITS];

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    logic [`ICACHE_TAG_BITS-1:0]  tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINE_BITS-1:0] line_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]     valid_bits;

    icache_state_e state;
    logic [7:0]    beat_cnt;  // beats received for this line
    logic          hit;
    logic          hit_take;
    logic          miss_take;
    word_t         sel_word;

    assign hit      = valid_bits[line_idx] && (tag_mem[line_idx] == addr_tag);
    // new lookup only when the previous answer has gone out
    assign hit_take  = (state == IC_IDLE) && fetch_valid && !fetch_ready && hit;
    assign miss_take = (state == IC_IDLE) && fetch_valid && !fetch_ready && !hit;
    assign sel_word  = line_mem[line_idx][32*word_sel +: 32];

    // a full line every time, burst or not decided downstream
    assign refill_len = 8'(`ICACHE_LINE_WORDS - 1);

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= IC_IDLE;
            refill_valid <= 1'b0;
            fetch_ready  <= 1'b0;
            beat_cnt     <= 8'd0;
            valid_bits   <= '0;  // all lines invalid
        end else begin
            fetch_ready <= 1'b0;  // single cycle pulse
            case (state)
                IC_IDLE: begin
                    if (hit_take) begin
                        fetch_ready <= 1'b1;
                    end else if (miss_take) begin
                        valid_bits[line_idx] <= 1'b0;  // line about to be overwritten
                        refill_valid         <= 1'b1;
                        beat_cnt             <= 8'd0;
                        state                <= IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (refill_beat) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (beat_cnt == refill_len) begin  // last beat
                            refill_valid <= 1'b0;
                            state        <= IC_RESPOND;
                        end
                    end
                end
                IC_RESPOND: begin
                    valid_bits[line_idx] <= 1'b1;
                    fetch_ready          <= 1'b1;
                    state                <= IC_IDLE;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // arrays and payload
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        // beats enter at the top, word 0 ends up in the low bits
        if (refill_beat) begin
            line_mem[line_idx] <= {refill_data, line_mem[line_idx][`ICACHE_LINE_BITS-1:32]};
        end
        if (state == IC_RESPOND) begin
            tag_mem[line_idx] <= addr_tag;
        end
        if (hit_take || (state == IC_RESPOND)) begin
            fetch_data <= sel_word;
        end
        if (miss_take) begin
            refill_addr  <= {fetch_addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
            refill_burst <= (fetch_addr[31:28] == `IFETCH_BURST_REGION);
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    // index and tag come straight from fetch_addr during the whole refill
    a_addr_stable: assert property (@(posedge clock) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr));

    a_beat_in_refill: assert property (@(posedge clock) disable iff (reset)
        refill_beat |-> state == IC_REFILL);

endmodule

//--- hw/refill_master.sv
`timescale 1ns/10ps

module refill_master (
    input  logic               clock,
    input  logic               reset,
    // cache side
    input  logic               refill_valid,
    input  ifetch_pkg::addr_t  refill_addr,
    input  logic [7:0]         refill_len,
    input  logic               refill_burst,
    output logic               refill_beat,
    output ifetch_pkg::word_t  refill_data,
    // memory port
    output logic               mem_req,
    output ifetch_pkg::addr_t  mem_addr,
    output logic [7:0]         mem_len,
    input  logic               mem_gnt,
    input  logic               mem_rvalid,
    input  ifetch_pkg::word_t  mem_rdata,
    input  logic               mem_rlast
);
    import ifetch_pkg::*;

    refill_state_e state;
    logic [7:0]    beat_cnt;   // beats of the current line so far
    logic          line_done;  // holds off until the cache drops refill_valid
    logic          start;
    logic          chain;

    // first request of a line
    assign start = (state == RM_IDLE) && refill_valid && !line_done;
    // next single beat request, only outside the burst region
    assign chain = (state == RM_RECEIVE) && mem_rvalid && mem_rlast && (beat_cnt != refill_len);

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= RM_IDLE;
            mem_req     <= 1'b0;
            refill_beat <= 1'b0;
            beat_cnt    <= 8'd0;
            line_done   <= 1'b0;
        end else begin
            refill_beat <= 1'b0;
            case (state)
                RM_IDLE: begin
                    if (!refill_valid) begin
                        line_done <= 1'b0;
                    end else if (start) begin
                        mem_req  <= 1'b1;
                        beat_cnt <= 8'd0;
                        state    <= RM_REQUEST;
                    end
                end
                RM_REQUEST: begin
                    if (mem_gnt) begin
                        mem_req <= 1'b0;
                        state   <= RM_RECEIVE;
                    end
                end
                RM_RECEIVE: begin
                    if (mem_rvalid) begin
                        refill_beat <= 1'b1;  // forwarded one cycle later
                        beat_cnt    <= beat_cnt + 8'd1;
                        if (chain) begin
                            mem_req <= 1'b1;
                            state   <= RM_REQUEST;
                        end else if (mem_rlast) begin
                            line_done <= 1'b1;
                            state     <= RM_IDLE;
                        end
                    end
                end
                default: state <= RM_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // request and beat payload
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (mem_rvalid) begin
            refill_data <= mem_rdata;
        end
        if (start) begin
            mem_addr <= refill_addr;
            mem_len  <= refill_burst ? refill_len : 8'd0;  // whole line or one word
        end else if (chain) begin
            mem_addr <= mem_addr + 32'd4;  // next word
            mem_len  <= 8'd0;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    a_rvalid_in_receive: assert property (@(posedge clock) disable iff (reset)
        mem_rvalid |-> state == RM_RECEIVE);

    // never more beats than the cache asked for
    a_beat_limit: assert property (@(posedge clock) disable iff (reset)
        mem_rvalid |-> beat_cnt <= refill_len);

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/10ps
`include "ifetch_defines.svh"

module fetch_unit (
    input  logic               clock,
    input  logic               reset,
    // control
    input  logic               stall,
    input  logic               redirect,
    input  ifetch_pkg::addr_t  redirect_pc,
    // cache side
    output logic               fetch_valid,
    output ifetch_pkg::addr_t  fetch_addr,
    input  logic               fetch_ready,
    input  ifetch_pkg::word_t  fetch_data,
    // decode side
    output logic               instr_valid,
    output ifetch_pkg::word_t  instr,
    output ifetch_pkg::addr_t  instr_pc
);
    import ifetch_pkg::*;

    fetch_state_e state;
    addr_t        pc;
    addr_t        redirect_hold;  // target while the old fetch drains

    // fetch is up whenever something is outstanding
    assign fetch_valid = (state != FE_RUN);
    assign fetch_addr  = pc;  // pc only moves between fetches

    // --------------------------------------------------
    // pc machine
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= FE_RUN;
            pc          <= `IFETCH_RESET_PC;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            case (state)
                FE_RUN: begin
                    if (redirect) begin
                        pc <= redirect_pc;  // visible next cycle
                    end
                    if (!stall) begin
                        state <= FE_WAIT;
                    end
                end
                FE_WAIT: begin
                    if (redirect) begin
                        if (fetch_ready) begin
                            pc    <= redirect_pc;  // answer is for the old path
                            state <= FE_RUN;
                        end else begin
                            state <= FE_DROP;
                        end
                    end else if (fetch_ready) begin
                        instr_valid <= 1'b1;
                        pc          <= pc + 32'd4;
                        if (stall) begin
                            state <= FE_RUN;  // park on the next pc
                        end
                    end
                end
                FE_DROP: begin
                    if (fetch_ready) begin
                        pc    <= redirect ? redirect_pc : redirect_hold;  // latest wins
                        state <= FE_RUN;
                    end
                end
                default: state <= FE_RUN;
            endcase
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (redirect && fetch_valid && !fetch_ready) begin
            redirect_hold <= redirect_pc;
        end
        if (fetch_ready) begin
            instr    <= fetch_data;
            instr_pc <= pc;
        end
    end

endmodule

//--- hw/ifetch_top.sv
`timescale 1ns/10ps

module ifetch_top (
    input  logic               clock,
    input  logic               reset,
    // core control
    input  logic               stall,
    input  logic               redirect,
    input  ifetch_pkg::addr_t  redirect_pc,
    // instruction out
    output logic               instr_valid,
    output ifetch_pkg::word_t  instr,
    output ifetch_pkg::addr_t  instr_pc,
    // memory port
    output logic               mem_req,
    output ifetch_pkg::addr_t  mem_addr,
    output logic [7:0]         mem_len,
    input  logic               mem_gnt,
    input  logic               mem_rvalid,
    input  ifetch_pkg::word_t  mem_rdata,
    input  logic               mem_rlast
);
    import ifetch_pkg::*;

    // --------------------------------------------------
    // fetch unit to cache
    // --------------------------------------------------

    logic  fetch_valid;
    addr_t fetch_addr;
    logic  fetch_ready;
    word_t fetch_data;

    // --------------------------------------------------
    // cache to refill master
    // --------------------------------------------------

    logic       refill_valid;
    addr_t      refill_addr;
    logic [7:0] refill_len;
    logic       refill_burst;
    logic       refill_beat;
    word_t      refill_data;

    fetch_unit fetch_unit_i (
        .clock, .reset, .stall, .redirect, .redirect_pc,
        .fetch_valid, .fetch_addr, .fetch_ready, .fetch_data,
        .instr_valid, .instr, .instr_pc
    );

    icache icache_i (
        .clock, .reset,
        .fetch_valid, .fetch_addr, .fetch_ready, .fetch_data,
        .refill_valid, .refill_addr, .refill_len, .refill_burst,
        .refill_beat, .refill_data
    );

    refill_master refill_master_i (
        .clock, .reset,
        .refill_valid, .refill_addr, .refill_len, .refill_burst,
        .refill_beat, .refill_data,
        .mem_req, .mem_addr, .mem_len, .mem_gnt, .mem_rvalid, .mem_rdata, .mem_rlast
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam int PERIOD       = 40;  // ns
    localparam int RESET_CYCLES = 5;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // power-on reset, released just after an edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
    input  logic               clock,
    input  logic               reset,
    input  logic               mem_req,
    input  ifetch_pkg::addr_t  mem_addr,
    input  logic [7:0]         mem_len,
    output logic               mem_gnt,
    output logic               mem_rvalid,
    output ifetch_pkg::word_t  mem_rdata,
    output logic               mem_rlast,
    output int                 req_count,   // granted requests
    output int                 beat_count   // returned beats
);
    import ifetch_pkg::*;

    localparam int DRIVE_DELAY = 2;
    localparam int MAX_GAP     = 3;  // idle cycles before gnt and before each beat

    // word i of a request is simply derived from its byte address
    function automatic word_t mem_word(input addr_t addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap) next_cycle();
    endtask

    // --------------------------------------------------
    // one request with a grant then len+1 beats
    // --------------------------------------------------

    task automatic serve_request();
        addr_t base;
        int    len;
        int    i;
        idle_gap();
        mem_gnt   = 1'b1;
        base      = mem_addr;  // held stable while mem_req is up
        len       = mem_len;
        req_count = req_count + 1;
        for (i = 0; i <= len; i++) begin
            next_cycle();
            mem_gnt    = 1'b0;
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            idle_gap();
            mem_rvalid = 1'b1;
            mem_rdata  = mem_word(base + 4 * i);
            mem_rlast  = (i == len);  // last beat of this request
            beat_count = beat_count + 1;
        end
    endtask

    initial begin
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_rlast  = 1'b0;
        req_count  = 0;
        beat_count = 0;
        void'($urandom(99859));  // single seed for the whole run
        forever begin
            next_cycle();
            mem_gnt    = 1'b0;
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            if (!reset && mem_req) begin
                serve_request();
            end
        end
    end

endmodule

//--- tb/tb_ifetch.sv
`timescale 1ns/10ps
`include "ifetch_defines.svh"

module tb_ifetch;
    import ifetch_pkg::*;

    // about 50 fetches in all, 20 cycles worst case each, 4x margin
    localparam int    TIMEOUT_CYCLES = 4000;
    localparam addr_t RESET_PC       = `IFETCH_RESET_PC;

    logic       clock;
    logic       reset;
    logic       stall;
    logic       redirect;
    addr_t      redirect_pc;
    logic       instr_valid;
    word_t      instr;
    addr_t      instr_pc;
    logic       mem_req;
    addr_t      mem_addr;
    logic [7:0] mem_len;
    logic       mem_gnt;
    logic       mem_rvalid;
    word_t      mem_rdata;
    logic       mem_rlast;
    int         req_count;
    int         beat_count;

    int         cycle_count = 0;
    int         checks      = 0;
    int         errors      = 0;
    int         tests       = 0;
    addr_t      got_pc [$];     // instructions seen in the current test
    word_t      got_instr [$];
    int         got_cycle [$];
    addr_t      req_addr_q [$];  // granted requests in the current test
    logic [7:0] req_len_q [$];

    tb_clock_gen clock_gen_i (.clock, .reset);

    tb_mem_model mem_i (
        .clock, .reset, .mem_req, .mem_addr, .mem_len,
        .mem_gnt, .mem_rvalid, .mem_rdata, .mem_rlast, .req_count, .beat_count
    );

    ifetch_top dut_i (
        .clock, .reset, .stall, .redirect, .redirect_pc,
        .instr_valid, .instr, .instr_pc,
        .mem_req, .mem_addr, .mem_len, .mem_gnt, .mem_rvalid, .mem_rdata, .mem_rlast
    );

    // --------------------------------------------------
    // monitor and timeout
    // --------------------------------------------------

    always @(negedge clock) begin
        if (!reset && mem_req && mem_gnt) begin
            req_addr_q.push_back(mem_addr);
            req_len_q.push_back(mem_len);
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    function automatic word_t expected_word(input addr_t pc);
        return pc ^ 32'h5a5a_5a5a;  // memory content rule
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        checks = checks + 1;
        assert (actual === expected) else begin
            errors = errors + 1;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic record_instr();
        if (instr_valid) begin
            got_pc.push_back(instr_pc);
            got_instr.push_back(instr);
            got_cycle.push_back(cycle_count);
        end
    endtask

    task automatic clear_log();
        got_pc.delete();
        got_instr.delete();
        got_cycle.delete();
        req_addr_q.delete();
        req_len_q.delete();
    endtask

    // fetch unit parked with stall high, so the pc moves and nothing starts
    task automatic steer(input addr_t pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        next_cycle();
        redirect    = 1'b0;
    endtask

    // stall goes up one instruction early so the last fetch parks the unit
    task automatic gather(input int n);
        stall = 1'b0;
        while (got_pc.size() < n) begin
            next_cycle();
            record_instr();
            stall = (got_pc.size() >= n - 1);
        end
    endtask

    task automatic check_stream(input addr_t base);
        int i;
        for (i = 0; i < got_pc.size(); i++) begin
            expect_equal(got_pc[i], base + 4 * i, "instr_pc");
            expect_equal(got_instr[i], expected_word(base + 4 * i), "instr");
        end
    endtask

    task automatic check_lens(input logic [7:0] len);
        int i;
        for (i = 0; i < req_len_q.size(); i++) begin
            expect_equal(req_len_q[i], len, "mem_len");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests = tests + 1;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic cold_fetch();
        int e0;
        int r0;
        int b0;
        int i;
        e0 = errors;
        expect_equal(mem_req, 1'b0, "mem_req after reset");
        expect_equal(instr_valid, 1'b0, "instr_valid after reset");
        clear_log();
        r0 = req_count;
        b0 = beat_count;
        gather(8);
        check_stream(RESET_PC);
        expect_equal(req_count - r0, 2, "burst request count");
        expect_equal(beat_count - b0, 8, "beat count");
        check_lens(8'd3);
        for (i = 0; i < req_addr_q.size(); i++) begin
            expect_equal(req_addr_q[i], RESET_PC + 16 * i, "burst mem_addr");
        end
        report_test("cold sequential fetch", e0);
    endtask

    task automatic hit_reuse();
        int e0;
        int r0;
        int i;
        e0 = errors;
        steer(RESET_PC);
        clear_log();
        r0 = req_count;
        gather(8);
        check_stream(RESET_PC);
        expect_equal(req_count - r0, 0, "requests on warm lines");
        for (i = 1; i < got_cycle.size(); i++) begin
            expect_equal(got_cycle[i] - got_cycle[i - 1], 2, "instr_valid spacing");
        end
        report_test("hit reuse and throughput", e0);
    endtask

    task automatic single_beat_region();
        int    e0;
        int    r0;
        int    i;
        addr_t base;
        e0   = errors;
        base = 32'h3000_0000;  // outside the burst region
        steer(base);
        clear_log();
        r0 = req_count;
        gather(4);
        check_stream(base);
        expect_equal(req_count - r0, 4, "single beat request count");
        check_lens(8'd0);
        for (i = 0; i < req_addr_q.size(); i++) begin
            expect_equal(req_addr_q[i], base + 4 * i, "single beat mem_addr");
        end
        report_test("non-burst region", e0);
    endtask

    task automatic redirect_in_miss();
        int    e0;
        addr_t old_pc;
        addr_t new_pc;
        e0     = errors;
        old_pc = 32'ha000_0420;  // cold line at index 2
        new_pc = 32'ha000_0834;
        steer(old_pc);
        clear_log();
        stall = 1'b0;
        do begin
            next_cycle();
            record_instr();
        end while (!mem_req);  // refill now outstanding
        redirect    = 1'b1;
        redirect_pc = new_pc;
        next_cycle();
        record_instr();
        redirect    = 1'b0;
        gather(2);
        check_stream(new_pc);  // old pc would show up as entry 0
        report_test("redirect during miss", e0);
    endtask

    task automatic conflict_evict();
        int    e0;
        int    r0;
        int    k;
        addr_t seq [3];
        e0  = errors;
        seq = '{32'ha000_0050, 32'ha000_1050, 32'ha000_0050};  // same index and two tags
        clear_log();
        r0 = req_count;
        for (k = 0; k < 3; k++) begin
            steer(seq[k]);
            gather(k + 1);
        end
        for (k = 0; k < got_pc.size(); k++) begin
            expect_equal(got_pc[k], seq[k], "instr_pc");
            expect_equal(got_instr[k], expected_word(seq[k]), "instr");
        end
        expect_equal(req_count - r0, 3, "refills for conflicting lines");
        check_lens(8'd3);
        report_test("conflict eviction", e0);
    endtask

    task automatic stall_hold();
        int    e0;
        int    r0;
        int    seen;
        addr_t base;
        e0   = errors;
        base = 32'ha000_0600;
        steer(base);
        clear_log();
        gather(12);  // warm three lines
        check_stream(base);
        steer(base);
        clear_log();
        r0    = req_count;
        stall = 1'b0;
        while (got_pc.size() < 3) begin
            next_cycle();
            record_instr();
        end
        stall = 1'b1;
        seen  = got_pc.size();
        repeat (20) begin
            next_cycle();
            record_instr();
        end
        checks = checks + 1;
        assert (got_pc.size() - seen <= 1) else begin
            errors = errors + 1;
            $display("[FAIL] %0d ns: %0d instructions while stalled, at most 1 expected",
                     $time, got_pc.size() - seen);
        end
        gather(8);
        check_stream(base);  // resumes at the next pc
        expect_equal(req_count - r0, 0, "requests with warm cache");
        report_test("stall", e0);
    endtask

    // --------------------------------------------------
    // sequence
    // --------------------------------------------------

    initial begin
        stall       = 1'b1;  // parked until a test releases it
        redirect    = 1'b0;
        redirect_pc = '0;
        @(negedge reset);
        next_cycle();
        cold_fetch();
        hit_reuse();
        single_beat_region();
        redirect_in_miss();
        conflict_evict();
        stall_hold();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/ifetch_pkg.sv
hw/icache.sv
hw/refill_master.sv
hw/fetch_unit.sv
hw/ifetch_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/tb_ifetch.sv

//--- Bender.yml
package:
  name: ifetch_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/ifetch_pkg.sv
      - hw/icache.sv
      - hw/refill_master.sv
      - hw/fetch_unit.sv
      - hw/ifetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_mem_model.sv
      - tb/tb_ifetch.sv
